// File: include/harness_macros.svh
//----------------------------------------------------------
// Harness constants
// Widths, depths, latency, region and host register codes
//----------------------------------------------------------
`ifndef HARNESS_MACROS_SVH
`define HARNESS_MACROS_SVH

`define HARNESS_ADDR_W      20
`define HARNESS_DATA_W      32
`define HARNESS_MEM_WORDS   1024
`define HARNESS_MEM_LAT     2
`define HARNESS_RESP_DEPTH  4
`define HARNESS_NUM_HARTS   4
`define HARNESS_NUM_EN      8

// Top address bits select the target
`define HARNESS_REGION_W    2
`define HARNESS_REGION_MEM  2'b00
`define HARNESS_REGION_HOST 2'b01

// Host address fields
`define HARNESS_REG_W       4
`define HARNESS_HART_W      2
`define HARNESS_REG_ENABLE  4'd0
`define HARNESS_REG_FINISH  4'd1

`endif

// File: hw/harness_pkg.sv
//----------------------------------------------------------
// Harness types
// Command, response, loader record and enable formats
//----------------------------------------------------------
`include "harness_macros.svh"

package harness_pkg;

  typedef enum logic {op_read = 1'b0, op_write = 1'b1} opcode_e;

  // Loader record kinds
  localparam logic [1:0] nbf_write_c  = 2'd0;
  localparam logic [1:0] nbf_fence_c  = 2'd1;
  localparam logic [1:0] nbf_finish_c = 2'd2;

  typedef struct packed {
    logic [`HARNESS_REGION_W-1:0]                  region;
    logic [`HARNESS_ADDR_W-`HARNESS_REGION_W-1:0]  offset;
  } mem_addr_s;

  typedef struct packed {
    logic [`HARNESS_REGION_W-1:0] region;
    logic [`HARNESS_ADDR_W-`HARNESS_REGION_W-`HARNESS_REG_W-`HARNESS_HART_W-1:0] rsvd;
    logic [`HARNESS_REG_W-1:0]    reg_idx;
    logic [`HARNESS_HART_W-1:0]   hart;
  } host_addr_s;

  // Same address word, seen by memory or by the host block
  typedef union packed {
    mem_addr_s  mem_addr;
    host_addr_s host_addr;
  } addr_u;

  typedef struct packed {
    opcode_e                    opcode;
    addr_u                      addr;
    logic [`HARNESS_DATA_W-1:0] data;
  } cmd_s;

  typedef struct packed {
    opcode_e                    opcode;
    addr_u                      addr;
    logic [`HARNESS_DATA_W-1:0] data;
    logic                       err;
  } resp_s;

  typedef struct packed {
    logic [1:0]                 kind;
    addr_u                      addr;
    logic [`HARNESS_DATA_W-1:0] data;
  } nbf_s;

  typedef struct packed {
    logic icache;
    logic dcache;
    logic lce;
    logic cce;
    logic dram;
    logic vm;
    logic cmt;
    logic profile;
  } enable_s;

endpackage

// File: hw/nbf_loader.sv
//----------------------------------------------------------
// NBF boot loader
// Issues load writes, fences on outstanding responses and
// raises a sticky done flag on the finish record
//----------------------------------------------------------
`timescale 1ns/100ps
`include "harness_macros.svh"

module nbf_loader
  (
    input  logic              clk_i,
    input  logic              reset_i,
    input  harness_pkg::nbf_s nbf_i,
    input  logic              nbf_v_i,
    output logic              nbf_ready_o,
    output harness_pkg::cmd_s cmd_o,
    output logic              cmd_v_o,
    input  logic              cmd_ready_i,
    input  logic              resp_v_i,
    output logic              done_o
  );

  localparam int cnt_w = $clog2(`HARNESS_RESP_DEPTH + 1);

  logic             done_r;
  logic [cnt_w-1:0] out_cnt_r;
  logic             drained;
  logic             cmd_fire;
  logic             nbf_fire;

  assign drained  = (out_cnt_r == '0);
  assign cmd_fire = cmd_v_o & cmd_ready_i;
  assign nbf_fire = nbf_v_i & nbf_ready_o;
  assign done_o   = done_r;

  assign cmd_o.opcode = harness_pkg::op_write;
  assign cmd_o.addr   = nbf_i.addr;
  assign cmd_o.data   = nbf_i.data;

  always_comb
  begin
    cmd_v_o     = 1'b0;
    nbf_ready_o = 1'b0;
    if (!done_r)
    begin
      case (nbf_i.kind)
        harness_pkg::nbf_write_c:
        begin
          cmd_v_o     = nbf_v_i;
          nbf_ready_o = cmd_ready_i;
        end
        harness_pkg::nbf_fence_c, harness_pkg::nbf_finish_c:
          nbf_ready_o = drained;
        // Unknown kinds are consumed and dropped
        default:
          nbf_ready_o = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      done_r    <= 1'b0;
      out_cnt_r <= '0;
    end
    else
    begin
      out_cnt_r <= out_cnt_r + cnt_w'(cmd_fire) - cnt_w'(resp_v_i);
      if (nbf_fire && nbf_i.kind == harness_pkg::nbf_finish_c)
        done_r <= 1'b1;
    end
  end

endmodule

// File: hw/io_router.sv
//----------------------------------------------------------
// Address router
// Picks loader or processor, decodes the region and keeps
// responses in command order across destinations
//----------------------------------------------------------
`timescale 1ns/100ps
`include "harness_macros.svh"

module io_router
  (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               done_i,
    input  harness_pkg::cmd_s  load_cmd_i,
    input  logic               load_cmd_v_i,
    output logic               load_cmd_ready_o,
    output logic               load_resp_v_o,
    input  harness_pkg::cmd_s  proc_cmd_i,
    input  logic               proc_cmd_v_i,
    output logic               proc_cmd_ready_o,
    output harness_pkg::resp_s proc_resp_o,
    output logic               proc_resp_v_o,
    input  logic               proc_resp_ready_i,
    output harness_pkg::cmd_s  mem_cmd_o,
    output logic               mem_cmd_v_o,
    input  logic               mem_cmd_ready_i,
    input  harness_pkg::resp_s mem_resp_i,
    input  logic               mem_resp_v_i,
    output logic               mem_resp_ready_o,
    output harness_pkg::cmd_s  host_cmd_o,
    output logic               host_cmd_v_o,
    input  logic               host_cmd_ready_i,
    input  harness_pkg::resp_s host_resp_i,
    input  logic               host_resp_v_i,
    output logic               host_resp_ready_o
  );

  localparam logic [1:0] dst_mem_c  = 2'd0;
  localparam logic [1:0] dst_host_c = 2'd1;
  localparam logic [1:0] dst_err_c  = 2'd2;
  localparam int         cnt_w      = $clog2(`HARNESS_RESP_DEPTH + 2);

  harness_pkg::cmd_s  cmd;
  logic               cmd_v;
  logic [1:0]         dst;
  logic               dst_ready;
  logic               blocked;
  logic               cmd_fire;
  logic [1:0]         last_dst_r;
  logic [cnt_w-1:0]   out_cnt_r;
  harness_pkg::resp_s err_resp_r;
  logic               err_v_r;
  harness_pkg::resp_s resp;
  logic               resp_v;
  logic               resp_ready;
  logic               resp_fire;

  assign cmd   = done_i ? proc_cmd_i : load_cmd_i;
  assign cmd_v = done_i ? proc_cmd_v_i : load_cmd_v_i;

  // Region field sits in the same bits of both views
  always_comb
  begin
    case (cmd.addr.mem_addr.region)
      `HARNESS_REGION_MEM:  dst = dst_mem_c;
      `HARNESS_REGION_HOST: dst = dst_host_c;
      default:              dst = dst_err_c;
    endcase
  end

  always_comb
  begin
    case (dst)
      dst_mem_c:  dst_ready = mem_cmd_ready_i;
      dst_host_c: dst_ready = host_cmd_ready_i;
      default:    dst_ready = ~err_v_r;
    endcase
  end

  // Switching target waits until the previous one has drained
  assign blocked  = (out_cnt_r != '0) && (dst != last_dst_r);
  assign cmd_fire = cmd_v & dst_ready & ~blocked;

  assign load_cmd_ready_o = ~done_i & dst_ready & ~blocked;
  assign proc_cmd_ready_o = done_i & dst_ready & ~blocked;

  assign mem_cmd_o    = cmd;
  assign mem_cmd_v_o  = cmd_v & ~blocked & (dst == dst_mem_c);
  assign host_cmd_o   = cmd;
  assign host_cmd_v_o = cmd_v & ~blocked & (dst == dst_host_c);

  // Only the last target can hold pending responses
  always_comb
  begin
    case (last_dst_r)
      dst_mem_c:
      begin
        resp   = mem_resp_i;
        resp_v = mem_resp_v_i;
      end
      dst_host_c:
      begin
        resp   = host_resp_i;
        resp_v = host_resp_v_i;
      end
      default:
      begin
        resp   = err_resp_r;
        resp_v = err_v_r;
      end
    endcase
  end

  // Loader is a sink that never stalls
  assign resp_ready        = done_i ? proc_resp_ready_i : 1'b1;
  assign resp_fire         = resp_v & resp_ready;
  assign mem_resp_ready_o  = resp_ready & (last_dst_r == dst_mem_c);
  assign host_resp_ready_o = resp_ready & (last_dst_r == dst_host_c);

  assign proc_resp_o   = resp;
  assign proc_resp_v_o = done_i & resp_v;
  assign load_resp_v_o = ~done_i & resp_v;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      last_dst_r <= dst_mem_c;
      out_cnt_r  <= '0;
      err_v_r    <= 1'b0;
    end
    else
    begin
      out_cnt_r <= out_cnt_r + cnt_w'(cmd_fire) - cnt_w'(resp_fire);
      if (cmd_fire)
        last_dst_r <= dst;
      if (cmd_fire && dst == dst_err_c)
        err_v_r <= 1'b1;
      else if (resp_fire && last_dst_r == dst_err_c)
        err_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire && dst == dst_err_c)
      err_resp_r <= '{opcode: cmd.opcode, addr: cmd.addr, data: '0, err: 1'b1};
  end

endmodule

// File: hw/host_regs.sv
//----------------------------------------------------------
// Host register block
// Feature enable bits and sticky per-hart finish flags
//----------------------------------------------------------
`timescale 1ns/100ps
`include "harness_macros.svh"

module host_regs
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  harness_pkg::cmd_s             cmd_i,
    input  logic                          cmd_v_i,
    output logic                          cmd_ready_o,
    output harness_pkg::resp_s            resp_o,
    output logic                          resp_v_o,
    input  logic                          resp_ready_i,
    output harness_pkg::enable_s          enable_o,
    output logic [`HARNESS_NUM_HARTS-1:0] finish_o
  );

  harness_pkg::host_addr_s       haddr;
  logic                          cmd_fire;
  logic                          is_enable;
  logic                          is_finish;
  logic                          is_write;
  logic [`HARNESS_DATA_W-1:0]    rd_data;
  harness_pkg::enable_s          enable_r;
  logic [`HARNESS_NUM_HARTS-1:0] finish_r;
  harness_pkg::resp_s            resp_r;
  logic                          resp_v_r;

  assign haddr     = cmd_i.addr.host_addr;
  assign is_enable = (haddr.reg_idx == `HARNESS_REG_ENABLE);
  assign is_finish = (haddr.reg_idx == `HARNESS_REG_FINISH);
  assign is_write  = (cmd_i.opcode == harness_pkg::op_write);

  // One request at a time until its response is taken
  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  // Finish reads return the whole flag vector
  always_comb
  begin
    rd_data = '0;
    if (is_enable)
      rd_data[`HARNESS_NUM_EN-1:0] = enable_r;
    else if (is_finish)
      rd_data[`HARNESS_NUM_HARTS-1:0] = finish_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      enable_r <= '0;
      finish_r <= '0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (cmd_fire && is_write && is_enable)
        enable_r <= harness_pkg::enable_s'(cmd_i.data[`HARNESS_NUM_EN-1:0]);
      if (cmd_fire && is_write && is_finish)
        finish_r[haddr.hart] <= 1'b1;
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      resp_r <= '{opcode: cmd_i.opcode,
                  addr:   cmd_i.addr,
                  data:   is_write ? '0 : rd_data,
                  err:    ~(is_enable | is_finish)};
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;
  assign enable_o = enable_r;
  assign finish_o = finish_r;

endmodule

// File: hw/mem_model.sv
//----------------------------------------------------------
// Memory model
// Word array behind a fixed-latency pipeline, with a
// response queue and credit-based back-pressure
//----------------------------------------------------------
`timescale 1ns/100ps
`include "harness_macros.svh"

module mem_model
  (
    input  logic               clk_i,
    input  logic               reset_i,
    input  harness_pkg::cmd_s  cmd_i,
    input  logic               cmd_v_i,
    output logic               cmd_ready_o,
    output harness_pkg::resp_s resp_o,
    output logic               resp_v_o,
    input  logic               resp_ready_i
  );

  localparam int lat_c   = `HARNESS_MEM_LAT;
  localparam int depth_c = `HARNESS_RESP_DEPTH;
  localparam int idx_w   = $clog2(`HARNESS_MEM_WORDS);
  localparam int ptr_w   = $clog2(depth_c);
  localparam int cnt_w   = $clog2(depth_c + 1);

  logic [`HARNESS_DATA_W-1:0] mem_r [`HARNESS_MEM_WORDS];
  logic [idx_w-1:0]           idx;
  logic                       cmd_fire;
  logic                       is_write;
  logic [lat_c-1:0]           pipe_v_r;
  harness_pkg::resp_s         pipe_r [lat_c];
  harness_pkg::resp_s         q_r [depth_c];
  logic [ptr_w-1:0]           wr_ptr_r;
  logic [ptr_w-1:0]           rd_ptr_r;
  logic [cnt_w-1:0]           q_cnt_r;
  logic [cnt_w-1:0]           in_flight;
  logic                       q_empty;
  logic                       push;
  logic                       pop;

  assign idx      = cmd_i.addr.mem_addr.offset[idx_w-1:0];
  assign is_write = (cmd_i.opcode == harness_pkg::op_write);
  assign cmd_fire = cmd_v_i & cmd_ready_o;

  always_comb
  begin
    in_flight = '0;
    for (int i = 0; i < lat_c; i++)
      in_flight = in_flight + cnt_w'(pipe_v_r[i]);
  end

  // Every accepted command owns a queue slot until it leaves
  assign cmd_ready_o = ({1'b0, in_flight} + {1'b0, q_cnt_r}) < (cnt_w + 1)'(depth_c);

  // Pipeline output bypasses an empty queue
  assign q_empty  = (q_cnt_r == '0);
  assign resp_v_o = q_empty ? pipe_v_r[lat_c-1] : 1'b1;
  assign resp_o   = q_empty ? pipe_r[lat_c-1] : q_r[rd_ptr_r];
  assign pop      = ~q_empty & resp_ready_i;
  assign push     = pipe_v_r[lat_c-1] & ~(q_empty & resp_ready_i);

  // Reads sample the array on acceptance and see all earlier writes
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire && is_write)
      mem_r[idx] <= cmd_i.data;
    pipe_r[0] <= '{opcode: cmd_i.opcode,
                   addr:   cmd_i.addr,
                   data:   is_write ? '0 : mem_r[idx],
                   err:    1'b0};
    for (int i = 1; i < lat_c; i++)
      pipe_r[i] <= pipe_r[i-1];
    if (push)
      q_r[wr_ptr_r] <= pipe_r[lat_c-1];
  end

  // Pointers wrap on a power-of-two depth
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pipe_v_r <= '0;
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      q_cnt_r  <= '0;
    end
    else
    begin
      pipe_v_r[0] <= cmd_fire;
      for (int i = 1; i < lat_c; i++)
        pipe_v_r[i] <= pipe_v_r[i-1];
      if (push)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      q_cnt_r <= q_cnt_r + cnt_w'(push) - cnt_w'(pop);
    end
  end

endmodule

// File: hw/harness_top.sv
//----------------------------------------------------------
// Harness top level
// Loader, router, host registers and memory on one port
//----------------------------------------------------------
`timescale 1ns/100ps
`include "harness_macros.svh"

module harness_top
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  harness_pkg::nbf_s             nbf_i,
    input  logic                          nbf_v_i,
    output logic                          nbf_ready_o,
    input  harness_pkg::cmd_s             proc_cmd_i,
    input  logic                          proc_cmd_v_i,
    output logic                          proc_cmd_ready_o,
    output harness_pkg::resp_s            proc_resp_o,
    output logic                          proc_resp_v_o,
    input  logic                          proc_resp_ready_i,
    output logic                          done_o,
    output harness_pkg::enable_s          enable_o,
    output logic [`HARNESS_NUM_HARTS-1:0] finish_o
  );

  harness_pkg::cmd_s  load_cmd;
  logic               load_cmd_v;
  logic               load_cmd_ready;
  logic               load_resp_v;
  harness_pkg::cmd_s  mem_cmd;
  logic               mem_cmd_v;
  logic               mem_cmd_ready;
  harness_pkg::resp_s mem_resp;
  logic               mem_resp_v;
  logic               mem_resp_ready;
  harness_pkg::cmd_s  host_cmd;
  logic               host_cmd_v;
  logic               host_cmd_ready;
  harness_pkg::resp_s host_resp;
  logic               host_resp_v;
  logic               host_resp_ready;

  nbf_loader loader
    (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .nbf_i       (nbf_i),
      .nbf_v_i     (nbf_v_i),
      .nbf_ready_o (nbf_ready_o),
      .cmd_o       (load_cmd),
      .cmd_v_o     (load_cmd_v),
      .cmd_ready_i (load_cmd_ready),
      .resp_v_i    (load_resp_v),
      .done_o      (done_o)
    );

  io_router router
    (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .done_i            (done_o),
      .load_cmd_i        (load_cmd),
      .load_cmd_v_i      (load_cmd_v),
      .load_cmd_ready_o  (load_cmd_ready),
      .load_resp_v_o     (load_resp_v),
      .proc_cmd_i        (proc_cmd_i),
      .proc_cmd_v_i      (proc_cmd_v_i),
      .proc_cmd_ready_o  (proc_cmd_ready_o),
      .proc_resp_o       (proc_resp_o),
      .proc_resp_v_o     (proc_resp_v_o),
      .proc_resp_ready_i (proc_resp_ready_i),
      .mem_cmd_o         (mem_cmd),
      .mem_cmd_v_o       (mem_cmd_v),
      .mem_cmd_ready_i   (mem_cmd_ready),
      .mem_resp_i        (mem_resp),
      .mem_resp_v_i      (mem_resp_v),
      .mem_resp_ready_o  (mem_resp_ready),
      .host_cmd_o        (host_cmd),
      .host_cmd_v_o      (host_cmd_v),
      .host_cmd_ready_i  (host_cmd_ready),
      .host_resp_i       (host_resp),
      .host_resp_v_i     (host_resp_v),
      .host_resp_ready_o (host_resp_ready)
    );

  host_regs host
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cmd_i        (host_cmd),
      .cmd_v_i      (host_cmd_v),
      .cmd_ready_o  (host_cmd_ready),
      .resp_o       (host_resp),
      .resp_v_o     (host_resp_v),
      .resp_ready_i (host_resp_ready),
      .enable_o     (enable_o),
      .finish_o     (finish_o)
    );

  mem_model mem
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cmd_i        (mem_cmd),
      .cmd_v_i      (mem_cmd_v),
      .cmd_ready_o  (mem_cmd_ready),
      .resp_o       (mem_resp),
      .resp_v_o     (mem_resp_v),
      .resp_ready_i (mem_resp_ready)
    );

endmodule

// File: sim/harness_props.sv
//----------------------------------------------------------
// Harness properties
// Handshake stability and reset rules on the top ports
//----------------------------------------------------------
`timescale 1ns/100ps

module harness_props
  (
    input logic               clk_i,
    input logic               reset_i,
    input harness_pkg::nbf_s  nbf_i,
    input logic               nbf_v_i,
    input logic               nbf_ready_o,
    input harness_pkg::cmd_s  proc_cmd_i,
    input logic               proc_cmd_v_i,
    input logic               proc_cmd_ready_o,
    input harness_pkg::resp_s proc_resp_o,
    input logic               proc_resp_v_o,
    input logic               proc_resp_ready_i
  );

  int fail_cnt = 0;

  resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    proc_resp_v_o && !proc_resp_ready_i |=> proc_resp_v_o && $stable(proc_resp_o))
    else
    begin
      $error("proc_resp_o changed before it was taken");
      fail_cnt++;
    end

  cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    proc_cmd_v_i && !proc_cmd_ready_o |=> proc_cmd_v_i && $stable(proc_cmd_i))
    else
    begin
      $error("proc_cmd_i changed before it was taken");
      fail_cnt++;
    end

  nbf_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    nbf_v_i && !nbf_ready_o |=> nbf_v_i && $stable(nbf_i))
    else
    begin
      $error("nbf_i changed before it was taken");
      fail_cnt++;
    end

  no_resp_in_reset: assert property (@(posedge clk_i) reset_i |=> !proc_resp_v_o)
    else
    begin
      $error("response valid while coming out of reset");
      fail_cnt++;
    end

endmodule

bind harness_top harness_props harness_props_i
  (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .nbf_i             (nbf_i),
    .nbf_v_i           (nbf_v_i),
    .nbf_ready_o       (nbf_ready_o),
    .proc_cmd_i        (proc_cmd_i),
    .proc_cmd_v_i      (proc_cmd_v_i),
    .proc_cmd_ready_o  (proc_cmd_ready_o),
    .proc_resp_o       (proc_resp_o),
    .proc_resp_v_o     (proc_resp_v_o),
    .proc_resp_ready_i (proc_resp_ready_i)
  );

// File: sim/harness_checker.sv
//----------------------------------------------------------
// Harness checker
// Reference model of memory and host registers, compares
// every processor response and the status outputs
//----------------------------------------------------------
`timescale 1ns/100ps
`include "harness_macros.svh"

module harness_checker
  (
    input logic                          clk_i,
    input logic                          reset_i,
    input harness_pkg::nbf_s             nbf_i,
    input logic                          nbf_v_i,
    input logic                          nbf_ready_o,
    input harness_pkg::cmd_s             proc_cmd_i,
    input logic                          proc_cmd_v_i,
    input logic                          proc_cmd_ready_o,
    input harness_pkg::resp_s            proc_resp_o,
    input logic                          proc_resp_v_o,
    input logic                          proc_resp_ready_i,
    input logic                          done_o,
    input harness_pkg::enable_s          enable_o,
    input logic [`HARNESS_NUM_HARTS-1:0] finish_o
  );

  logic [31:0]                   mem_m [1024];
  logic [7:0]                    enable_m;
  logic [`HARNESS_NUM_HARTS-1:0] finish_m;
  harness_pkg::resp_s            exp_q [$];
  harness_pkg::resp_s            exp;
  logic                          seen_reset = 1'b0;
  int                            errors = 0;
  int                            tests = 0;
  int                            failed = 0;
  int                            test_start = 0;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("Error: %s", what);
    errors++;
  endtask

  task automatic check_idle();
    compare("done_o", 32'(done_o), '0);
    compare("proc_cmd_ready_o", 32'(proc_cmd_ready_o), '0);
    compare("proc_resp_v_o", 32'(proc_resp_v_o), '0);
    compare("enable_o", 32'(enable_o), '0);
    compare("finish_o", 32'(finish_o), '0);
  endtask

  // Expected response per the address map, updating the model
  function automatic harness_pkg::resp_s predict(input harness_pkg::cmd_s c);
    harness_pkg::resp_s r;
    logic               wr;
    wr = (c.opcode == harness_pkg::op_write);
    r  = '{opcode: c.opcode, addr: c.addr, data: '0, err: 1'b0};
    if (c.addr.mem_addr.region == `HARNESS_REGION_MEM)
    begin
      if (wr)
        mem_m[c.addr.mem_addr.offset[9:0]] = c.data;
      else
        r.data = mem_m[c.addr.mem_addr.offset[9:0]];
    end
    else if (c.addr.host_addr.region == `HARNESS_REGION_HOST &&
             c.addr.host_addr.reg_idx == `HARNESS_REG_ENABLE)
    begin
      if (wr)
        enable_m = c.data[7:0];
      else
        r.data = 32'(enable_m);
    end
    else if (c.addr.host_addr.region == `HARNESS_REGION_HOST &&
             c.addr.host_addr.reg_idx == `HARNESS_REG_FINISH)
    begin
      if (wr)
        finish_m[c.addr.host_addr.hart] = 1'b1;
      else
        r.data = 32'(finish_m);
    end
    else
      r.err = 1'b1;
    return r;
  endfunction

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      exp_q.delete();
      enable_m = '0;
      finish_m = '0;
      if (seen_reset)
        check_idle();
      seen_reset = 1'b1;
    end
    else
    begin
      compare("enable_o", 32'(enable_o), 32'(enable_m));
      compare("finish_o", 32'(finish_o), 32'(finish_m));
      // Only one source owns the router at a time
      if (done_o)
        compare("nbf_ready_o", 32'(nbf_ready_o), '0);
      else
        compare("proc_cmd_ready_o", 32'(proc_cmd_ready_o), '0);
      if (proc_resp_v_o && proc_resp_ready_i)
      begin
        if (exp_q.size() == 0)
          note_failure("a response arrived with no command outstanding");
        else
        begin
          exp = exp_q.pop_front();
          compare("proc_resp_o.opcode", 32'(proc_resp_o.opcode), 32'(exp.opcode));
          compare("proc_resp_o.addr", 32'(proc_resp_o.addr), 32'(exp.addr));
          compare("proc_resp_o.data", proc_resp_o.data, exp.data);
          compare("proc_resp_o.err", 32'(proc_resp_o.err), 32'(exp.err));
        end
      end
      if (nbf_v_i && nbf_ready_o && nbf_i.kind == harness_pkg::nbf_write_c)
        mem_m[nbf_i.addr.mem_addr.offset[9:0]] = nbf_i.data;
      if (proc_cmd_v_i && proc_cmd_ready_o)
        exp_q.push_back(predict(proc_cmd_i));
    end
  end

  function automatic int pending();
    return exp_q.size();
  endfunction

  function automatic int failed_count();
    return failed;
  endfunction

  task automatic end_test(input string name);
    tests++;
    if (errors == test_start)
      $display("Test %0d %s: ok", tests, name);
    else
    begin
      failed++;
      $display("Test %0d %s: %0d errors", tests, name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic report();
    $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
  endtask

endmodule

// File: sim/harness_tb.sv
//----------------------------------------------------------
// Harness testbench
// Clock, reset, random stimulus and watchdog around the DUT
//----------------------------------------------------------
`timescale 1ns/100ps
`include "harness_macros.svh"

module harness_tb;

  localparam int num_tests   = 6;
  localparam int test_budget = 3000;
  localparam int clk_period  = 100;

  logic                          clk_i;
  logic                          reset_i;
  harness_pkg::nbf_s             nbf_i;
  logic                          nbf_v_i;
  logic                          nbf_ready_o;
  harness_pkg::cmd_s             proc_cmd_i;
  logic                          proc_cmd_v_i;
  logic                          proc_cmd_ready_o;
  harness_pkg::resp_s            proc_resp_o;
  logic                          proc_resp_v_o;
  logic                          proc_resp_ready_i;
  logic                          done_o;
  harness_pkg::enable_s          enable_o;
  logic [`HARNESS_NUM_HARTS-1:0] finish_o;

  logic [31:0] rng;
  logic [31:0] rdy_rng;
  logic        stall_en;
  logic [9:0]  loaded_q [$];

  harness_top harness_top_i (.*);

  harness_checker harness_checker_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [19:0] mem_addr(input logic [9:0] off);
    return {`HARNESS_REGION_MEM, 8'h00, off};
  endfunction

  function automatic logic [19:0] host_addr(input logic [3:0] idx, input logic [1:0] hart);
    return {`HARNESS_REGION_HOST, 12'h000, idx, hart};
  endfunction

  task automatic send_nbf(input logic [1:0] kind, input logic [19:0] addr,
                          input logic [31:0] data);
    @(posedge clk_i);
    nbf_i   <= '{kind: kind, addr: addr, data: data};
    nbf_v_i <= 1'b1;
    do
      @(negedge clk_i);
    while (!nbf_ready_o);
    @(posedge clk_i);
    nbf_v_i <= 1'b0;
  endtask

  task automatic send_cmd(input logic write, input logic [19:0] addr,
                          input logic [31:0] data);
    @(posedge clk_i);
    proc_cmd_i   <= '{opcode: harness_pkg::opcode_e'(write), addr: addr, data: data};
    proc_cmd_v_i <= 1'b1;
    do
      @(negedge clk_i);
    while (!proc_cmd_ready_o);
    @(posedge clk_i);
    proc_cmd_v_i <= 1'b0;
  endtask

  // Waits for every issued command to be answered
  task automatic drain();
    do
      @(negedge clk_i);
    while (harness_checker_i.pending() != 0);
  endtask

  // Random mix of memory window and enable register traffic
  task automatic random_traffic(input int count, input logic with_host);
    repeat (count)
    begin
      rng = xorshift(rng);
      if (with_host && rng[7:6] == 2'b00)
        send_cmd(rng[0], host_addr(`HARNESS_REG_ENABLE, 2'd0), xorshift(rng));
      else
        send_cmd(rng[0], mem_addr({5'd0, rng[12:8]}), xorshift(rng));
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever
      #(clk_period / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    rdy_rng = xorshift(rdy_rng);
    proc_resp_ready_i <= stall_en ? (rdy_rng[1:0] != 2'b00) : 1'b1;
  end

  initial
  begin
    #(num_tests * test_budget * clk_period);
    $display("Timeout: the run did not finish within its cycle budget");
    $display("tests failed");
    $finish;
  end

  initial
  begin
    reset_i           = 1'b1;
    nbf_i             = '0;
    nbf_v_i           = 1'b0;
    proc_cmd_i        = '0;
    proc_cmd_v_i      = 1'b0;
    proc_resp_ready_i = 1'b1;
    stall_en          = 1'b0;
    rng               = 32'hb764_22c3;
    rdy_rng           = xorshift(32'hb764_22c3);
    repeat (4)
      @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    harness_checker_i.check_idle();
    harness_checker_i.end_test("reset state");

    repeat (16)
    begin
      rng = xorshift(rng);
      loaded_q.push_back(rng[9:0]);
      send_nbf(harness_pkg::nbf_write_c, mem_addr(rng[9:0]), xorshift(rng));
    end
    send_nbf(harness_pkg::nbf_fence_c, '0, '0);
    send_nbf(harness_pkg::nbf_finish_c, '0, '0);
    @(negedge clk_i);
    if (!done_o)
      harness_checker_i.note_failure("done_o did not rise after the finish record");
    foreach (loaded_q[i])
      send_cmd(1'b0, mem_addr(loaded_q[i]), '0);
    drain();
    harness_checker_i.end_test("boot load");

    // Fill the window so every later read has known data
    for (int i = 0; i < 32; i++)
    begin
      rng = xorshift(rng);
      send_cmd(1'b1, mem_addr(10'(i)), rng);
    end
    random_traffic(200, 1'b0);
    drain();
    harness_checker_i.end_test("memory traffic");

    repeat (24)
    begin
      rng = xorshift(rng);
      if (rng[3])
        send_cmd(rng[0], host_addr(`HARNESS_REG_FINISH, rng[5:4]), '0);
      else
        send_cmd(rng[0], host_addr(`HARNESS_REG_ENABLE, 2'd0), xorshift(rng));
    end
    drain();
    harness_checker_i.end_test("host registers");

    stall_en <= 1'b1;
    random_traffic(200, 1'b1);
    drain();
    stall_en <= 1'b0;
    harness_checker_i.end_test("response back-pressure");

    repeat (30)
    begin
      rng = xorshift(rng);
      case (rng[9:8])
        2'd0: send_cmd(rng[0], {2'b10, rng[27:10]}, xorshift(rng));
        2'd1: send_cmd(rng[0], {2'b11, rng[27:10]}, xorshift(rng));
        2'd2: send_cmd(rng[0], host_addr(4'd2 + 4'(rng[15:12] % 14), rng[5:4]), rng);
        default: send_cmd(1'b0, mem_addr({5'd0, rng[20:16]}), '0);
      endcase
    end
    drain();
    harness_checker_i.end_test("unmapped addresses");

    harness_checker_i.report();
    if (harness_checker_i.failed_count() == 0 &&
        harness_top_i.harness_props_i.fail_cnt == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
hw/harness_pkg.sv
hw/nbf_loader.sv
hw/io_router.sv
hw/host_regs.sv
hw/mem_model.sv
hw/harness_top.sv
sim/harness_props.sv
sim/harness_checker.sv
sim/harness_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module harness_tb

sim:
	verilator --binary --timing --assert -f verilog.f --top-module harness_tb -o Vharness_tb
	@out=$$(./obj_dir/Vharness_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
